/* csi2_rx_raw10.f */
src/csi2_pkg.sv
src/pixel_pkg.sv
src/stream_reg.sv
src/csi2_packet_fsm.sv
src/payload_counter.sv
src/raw10_unpacker.sv
src/csi2_rx_raw10.sv
bench/tb_csi2_rx_raw10.sv

/* Bender.yml */
package:
  name: csi2_rx_raw10

sources:
  - src/csi2_pkg.sv
  - src/pixel_pkg.sv
  - src/stream_reg.sv
  - src/csi2_packet_fsm.sv
  - src/payload_counter.sv
  - src/raw10_unpacker.sv
  - src/csi2_rx_raw10.sv
  - target: test
    files:
      - bench/tb_csi2_rx_raw10.sv

/* bench/tb_csi2_rx_raw10.sv */
`timescale 1ns/1ps

module tb_csi2_rx_raw10;

    import csi2_pkg::*;
    import pixel_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'h89b9_12ab;
    localparam logic [5:0]  dt_raw8   = 6'h2a;
    localparam int          timeout   = 2000;    // cycles allowed in any one wait loop

    logic                   aclk;
    logic                   rst;
    logic [byte_width-1:0]  s_data;
    logic                   s_valid;
    logic                   s_ready;
    logic [pixel_width-1:0] m_pixel;
    logic                   m_frame_start;
    logic                   m_line_end;
    logic                   m_valid;
    logic                   m_ready;

    logic [31:0]            stim_state;
    logic [31:0]            ready_state;
    logic                   random_ready;
    logic                   fs_model;    // a frame start still waits for its first pixel
    string                  test_name;
    logic [byte_width-1:0]  tx_q[$];
    pixel_beat_t            exp_q[$];
    string                  name_q[$];   // test that queued each expected pixel

    csi2_rx_raw10 i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // taps 32, 22, 2 and 1, the new bit enters at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_next(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // pixel k takes byte k as its upper bits and bits 2k+1..2k of byte 4 as the lower two
    function automatic logic [pixel_width-1:0] raw10_pixel(input logic [7:0] msb_byte,
                                                          input logic [7:0] lsb_byte,
                                                          input int k);
        return {msb_byte, lsb_byte[2*k +: 2]};
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                               name, field, expected, actual));
        end
    endtask

    // data identifier with a random virtual channel, word count and ECC filler
    task automatic add_header(input logic [5:0] dt, input logic [15:0] count);
        logic [31:0] r;
        draw_bits(stim_state, 10, r);
        tx_q.push_back({r[9:8], dt});
        tx_q.push_back(count[7:0]);
        tx_q.push_back(count[15:8]);
        tx_q.push_back(r[7:0]);
    endtask

    task automatic add_short(input logic [5:0] dt);
        logic [31:0] r;
        draw_bits(stim_state, 16, r);    // frame or line number, not used by the DUT
        add_header(dt, r[15:0]);
        if (dt == dt_frame_start) begin
            fs_model = 1'b1;
        end
    endtask

    task automatic add_long(input logic [5:0] dt, input int count);
        logic [31:0] r;
        pixel_beat_t beat;
        int          base;
        int          last_grp;
        add_header(dt, 16'(count));
        base = tx_q.size();
        for (int i = 0; i < count + crc_bytes; i++) begin
            draw_bits(stim_state, byte_width, r);    // payload, then CRC filler
            tx_q.push_back(r[7:0]);
        end
        last_grp = count / group_bytes - 1;    // a partial tail group gives no pixels
        if (dt == dt_raw10) begin
            for (int g = 0; g <= last_grp; g++) begin
                for (int k = 0; k < group_pixels; k++) begin
                    beat.pixel       = raw10_pixel(tx_q[base + g*group_bytes + k],
                                                   tx_q[base + g*group_bytes + 4], k);
                    beat.frame_start = fs_model;
                    beat.line_end    = g == last_grp && k == group_pixels - 1;
                    fs_model         = 1'b0;
                    exp_q.push_back(beat);
                    name_q.push_back(test_name);
                end
            end
        end
    endtask

    // offers one byte per cycle, idle cycles are mixed in when gapped is set
    task automatic send_bytes(input logic gapped);
        logic [31:0] r;
        int          cycles;
        while (tx_q.size() != 0) begin
            @(posedge aclk);
            #1;
            draw_bits(stim_state, 2, r);
            s_valid = !(gapped && r[1:0] == 2'b00);
            s_data  = tx_q[0];
            cycles  = 0;
            @(negedge aclk);
            while (s_valid && !s_ready) begin
                cycles++;
                if (cycles > timeout) begin
                    fail_run("an input byte was never accepted, s_ready stayed low");
                end
                @(negedge aclk);
            end
            if (s_valid) begin
                void'(tx_q.pop_front());
            end
        end
        @(posedge aclk);
        #1;
        s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge aclk);
            cycles++;
            if (cycles > timeout) begin
                fail_run($sformatf("%s timed out with %0d pixels still missing",
                                   test_name, exp_q.size()));
            end
        end
        repeat (16) @(negedge aclk);    // room for a stray pixel to show up
    endtask

    always @(posedge aclk) begin : ready_drive
        logic [31:0] r;
        #1;
        if (random_ready) begin
            draw_bits(ready_state, 1, r);
            m_ready = r[0];
        end else begin
            m_ready = 1'b1;
        end
    end

    // a beat moves on the next rising edge, so its values are read half a cycle earlier
    always @(negedge aclk) begin : compare
        pixel_beat_t exp_beat;
        string       exp_name;
        if (!rst && m_valid && m_ready) begin
            assert (exp_q.size() != 0) else begin
                fail_run($sformatf("pixel %03h arrived in %s with no pixel expected",
                                   m_pixel, test_name));
            end
            exp_beat = exp_q.pop_front();
            exp_name = name_q.pop_front();
            check_value(exp_name, "pixel", 16'(exp_beat.pixel), 16'(m_pixel));
            check_value(exp_name, "frame_start", 16'(exp_beat.frame_start), 16'(m_frame_start));
            check_value(exp_name, "line_end", 16'(exp_beat.line_end), 16'(m_line_end));
        end
    end

    initial begin : main
        int cycles;
        rst          = 1'b1;
        s_valid      = 1'b0;
        s_data       = '0;
        m_ready      = 1'b0;
        random_ready = 1'b0;
        fs_model     = 1'b0;
        stim_state   = lfsr_seed;
        ready_state  = lfsr_seed;
        test_name    = "idle_after_reset";
        repeat (3) @(posedge aclk);
        #1;
        rst    = 1'b0;
        cycles = 0;
        @(negedge aclk);
        while (!s_ready) begin
            cycles++;
            if (cycles > timeout) begin
                fail_run("s_ready did not rise after reset");
            end
            @(negedge aclk);
        end
        repeat (8) begin
            @(negedge aclk);
            check_value(test_name, "m_valid", 16'd0, 16'(m_valid));
        end

        test_name = "single_line";
        add_long(dt_raw10, 20);
        send_bytes(1'b0);
        wait_drain();

        test_name = "frame_start_two_lines";
        add_short(dt_frame_start);
        add_long(dt_raw10, 15);
        add_long(dt_raw10, 10);
        send_bytes(1'b0);
        wait_drain();

        test_name = "other_type_dropped";
        add_long(dt_raw10, 10);
        add_long(dt_raw8, 13);
        add_long(dt_raw10, 20);
        send_bytes(1'b0);
        wait_drain();

        test_name    = "random_back_pressure";
        random_ready = 1'b1;
        add_short(dt_frame_start);
        add_long(dt_raw10, 40);
        add_short(dt_frame_end);
        add_long(6'h12, 7);    // embedded data, dropped like any other type
        add_long(dt_raw10, 25);
        add_long(dt_raw10, 35);
        send_bytes(1'b1);
        wait_drain();
        random_ready = 1'b0;

        test_name = "frame_end_and_empty_packet";
        add_short(dt_frame_end);
        add_long(dt_raw10, 0);
        add_long(dt_raw10, 20);
        send_bytes(1'b0);
        wait_drain();

        $display("TEST OK");
        $finish;
    end

endmodule

/* src/csi2_rx_raw10.sv */
`timescale 1ns/1ps

module csi2_rx_raw10 (
    input  logic                              aclk,
    input  logic                              rst,

    input  logic [pixel_pkg::byte_width-1:0]  s_data,
    input  logic                              s_valid,
    output logic                              s_ready,

    output logic [pixel_pkg::pixel_width-1:0] m_pixel,
    output logic                              m_frame_start,
    output logic                              m_line_end,
    output logic                              m_valid,
    input  logic                              m_ready
);

    import csi2_pkg::*;
    import pixel_pkg::*;

    byte_beat_t            in_beat;
    byte_beat_t            byte_beat;
    logic                  byte_valid;
    logic                  byte_ready;

    logic                  load;
    logic [wc_width-1:0]   wc;
    logic                  step;
    logic                  payload_done;
    logic                  crc_done;

    logic [byte_width-1:0] unp_data;
    logic                  unp_valid;
    logic                  unp_ready;
    logic                  unp_last;
    logic                  frame_start_seen;

    pixel_beat_t           pix_beat;
    logic                  pix_valid;
    logic                  pix_ready;
    pixel_beat_t           out_beat;

    assign in_beat.data = s_data;

    stream_reg #(.payload_t(byte_beat_t)) i_in_reg (
        .aclk      (aclk),
        .rst       (rst),
        .s_payload (in_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .m_payload (byte_beat),
        .m_valid   (byte_valid),
        .m_ready   (byte_ready)
    );

    csi2_packet_fsm i_fsm (
        .aclk             (aclk),
        .rst              (rst),
        .byte_data        (byte_beat),
        .byte_valid       (byte_valid),
        .byte_ready       (byte_ready),
        .load             (load),
        .wc               (wc),
        .step             (step),
        .payload_done     (payload_done),
        .crc_done         (crc_done),
        .unp_data         (unp_data),
        .unp_valid        (unp_valid),
        .unp_ready        (unp_ready),
        .unp_last         (unp_last),
        .frame_start_seen (frame_start_seen)
    );

    payload_counter i_counter (
        .aclk         (aclk),
        .rst          (rst),
        .load         (load),
        .wc           (wc),
        .step         (step),
        .payload_done (payload_done),
        .crc_done     (crc_done)
    );

    raw10_unpacker i_unpacker (
        .aclk             (aclk),
        .rst              (rst),
        .unp_data         (unp_data),
        .unp_valid        (unp_valid),
        .unp_ready        (unp_ready),
        .unp_last         (unp_last),
        .frame_start_seen (frame_start_seen),
        .m_beat           (pix_beat),
        .m_valid          (pix_valid),
        .m_ready          (pix_ready)
    );

    stream_reg #(.payload_t(pixel_beat_t)) i_out_reg (
        .aclk      (aclk),
        .rst       (rst),
        .s_payload (pix_beat),
        .s_valid   (pix_valid),
        .s_ready   (pix_ready),
        .m_payload (out_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

    assign m_pixel       = out_beat.pixel;
    assign m_frame_start = out_beat.frame_start;
    assign m_line_end    = out_beat.line_end;

endmodule

/* src/raw10_unpacker.sv */
`timescale 1ns/1ps

module raw10_unpacker (
    input  logic                              aclk,
    input  logic                              rst,

    input  logic [pixel_pkg::byte_width-1:0]  unp_data,
    input  logic                              unp_valid,
    output logic                              unp_ready,
    input  logic                              unp_last,
    input  logic                              frame_start_seen,

    output pixel_pkg::pixel_beat_t            m_beat,
    output logic                              m_valid,
    input  logic                              m_ready
);

    import pixel_pkg::*;

    logic [byte_width-1:0]             grp [group_bytes];
    logic [byte_width-1:0]             lsb_byte;
    logic [$clog2(group_bytes)-1:0]    byte_idx;
    logic [$clog2(group_pixels)-1:0]   pix_idx;
    logic                              emitting;
    logic                              fs_pending;
    logic                              grp_fs;      // group opens a frame
    logic                              grp_last;    // group holds the last byte of the line
    logic                              in_fire;
    logic                              out_fire;

    // input and output phases alternate, so the two never fire together
    assign unp_ready = !emitting;
    assign m_valid   = emitting;
    assign in_fire   = unp_valid && unp_ready;
    assign out_fire  = m_valid && m_ready;

    assign lsb_byte = grp[group_bytes - 1];    // low bits of all four pixels

    always_comb begin
        m_beat.pixel       = {grp[pix_idx], lsb_byte[2*pix_idx +: pixel_width - byte_width]};
        m_beat.frame_start = grp_fs && pix_idx == '0;
        m_beat.line_end    = grp_last && pix_idx == group_pixels - 1;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            byte_idx   <= '0;
            pix_idx    <= '0;
            emitting   <= 1'b0;
            fs_pending <= 1'b0;
            grp_fs     <= 1'b0;
            grp_last   <= 1'b0;
        end else begin
            // a new frame start wins over clearing the old one
            if (frame_start_seen) begin
                fs_pending <= 1'b1;
            end else if (out_fire && m_beat.frame_start) begin
                fs_pending <= 1'b0;
            end

            if (in_fire) begin
                if (byte_idx == '0) begin
                    grp_fs <= fs_pending;
                end
                if (byte_idx == group_bytes - 1) begin
                    byte_idx <= '0;
                    emitting <= 1'b1;
                    grp_last <= unp_last;
                end else if (unp_last) begin
                    byte_idx <= '0;    // incomplete tail of the line is thrown away
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end

            if (out_fire) begin
                pix_idx <= pix_idx + 1'b1;
                if (pix_idx == group_pixels - 1) begin
                    emitting <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire) begin
            grp[byte_idx] <= unp_data;
        end
    end

    a_byte_idx_range: assert property (@(posedge aclk) disable iff (rst)
        byte_idx < group_bytes);

    // the pixel index only runs while a group is being emitted
    a_pix_idx_range: assert property (@(posedge aclk) disable iff (rst)
        pix_idx < group_pixels && (emitting || pix_idx == '0));

endmodule

/* src/payload_counter.sv */
`timescale 1ns/1ps

module payload_counter (
    input  logic                          aclk,
    input  logic                          rst,

    input  logic                          load,
    input  logic [csi2_pkg::wc_width-1:0] wc,
    input  logic                          step,

    output logic                          payload_done,
    output logic                          crc_done
);

    import csi2_pkg::*;

    typedef logic [$clog2(crc_bytes + 1)-1:0] crc_cnt_t;

    logic [wc_width-1:0] pay_cnt;    // payload bytes still to come, current one included
    crc_cnt_t            crc_cnt;

    assign payload_done = pay_cnt == 1;
    assign crc_done     = pay_cnt == '0 && crc_cnt == 1;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pay_cnt <= '0;
            crc_cnt <= '0;
        end else if (load) begin
            pay_cnt <= wc;
            crc_cnt <= crc_cnt_t'(crc_bytes);
        end else if (step) begin
            // payload first, the CRC count only moves once the payload is used up
            if (pay_cnt != '0) begin
                pay_cnt <= pay_cnt - 1'b1;
            end else begin
                crc_cnt <= crc_cnt - 1'b1;
            end
        end
    end

    a_no_step_when_empty: assert property (@(posedge aclk) disable iff (rst)
        step |-> pay_cnt != '0 || crc_cnt != '0);

    // the FSM only reloads once the previous packet has been fully consumed
    a_load_when_empty: assert property (@(posedge aclk) disable iff (rst)
        load |-> pay_cnt == '0 && crc_cnt == '0);

endmodule

/* src/csi2_packet_fsm.sv */
`timescale 1ns/1ps

module csi2_packet_fsm (
    input  logic                              aclk,
    input  logic                              rst,

    input  pixel_pkg::byte_beat_t             byte_data,
    input  logic                              byte_valid,
    output logic                              byte_ready,

    output logic                              load,
    output logic [csi2_pkg::wc_width-1:0]     wc,
    output logic                              step,
    input  logic                              payload_done,
    input  logic                              crc_done,

    output logic [pixel_pkg::byte_width-1:0]  unp_data,
    output logic                              unp_valid,
    input  logic                              unp_ready,
    output logic                              unp_last,
    output logic                              frame_start_seen
);

    import csi2_pkg::*;
    import pixel_pkg::*;

    typedef enum logic [1:0] {
        st_header,
        st_payload,
        st_crc
    } state_t;

    state_t                          state;
    logic [$clog2(header_bytes)-1:0] hdr_idx;
    logic [5:0]                      hdr_dt;
    logic [byte_width-1:0]           wc_lo;
    logic [byte_width-1:0]           wc_hi;
    logic                            is_raw10;
    logic                            byte_fire;
    logic                            hdr_done;
    logic                            hdr_long;

    assign byte_fire = byte_valid && byte_ready;
    assign hdr_done  = byte_fire && state == st_header && hdr_idx == header_bytes - 1;
    assign hdr_long  = hdr_dt > dt_short_max;

    assign wc   = {wc_hi, wc_lo};
    assign load = hdr_done && hdr_long;    // ECC byte of a long header
    assign step = byte_fire && state != st_header;

    // only RAW10 payload can stall, everything else is swallowed at line rate
    assign byte_ready = (state == st_payload && is_raw10) ? unp_ready : 1'b1;

    assign unp_data  = byte_data.data;
    assign unp_valid = byte_valid && state == st_payload && is_raw10;
    assign unp_last  = payload_done;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state            <= st_header;
            hdr_idx          <= '0;
            is_raw10         <= 1'b0;
            frame_start_seen <= 1'b0;
        end else begin
            frame_start_seen <= 1'b0;
            case (state)
                st_header: begin
                    if (byte_fire) begin
                        hdr_idx <= hdr_idx + 1'b1;    // wraps back to zero after the ECC byte
                    end
                    if (hdr_done && hdr_long) begin
                        is_raw10 <= hdr_dt == dt_raw10;
                        state    <= (wc == '0) ? st_crc : st_payload;
                    end else if (hdr_done) begin
                        // frame end and the generic short packets have no effect
                        frame_start_seen <= hdr_dt == dt_frame_start;
                    end
                end
                st_payload: begin
                    if (byte_fire && payload_done) begin
                        state <= st_crc;
                    end
                end
                st_crc: begin
                    if (byte_fire && crc_done) begin
                        state <= st_header;
                    end
                end
                default: state <= st_header;
            endcase
        end
    end

    // header fields, the ECC byte itself is not kept
    always_ff @(posedge aclk) begin
        if (byte_fire && state == st_header) begin
            case (hdr_idx)
                2'd0:    hdr_dt <= byte_data.data[5:0];    // virtual channel bits dropped
                2'd1:    wc_lo  <= byte_data.data;
                2'd2:    wc_hi  <= byte_data.data;
                default: ;
            endcase
        end
    end

    // a forwarded byte must still lie inside the word count held by the counter
    a_unp_in_payload: assert property (@(posedge aclk) disable iff (rst)
        unp_valid |-> state == st_payload && is_raw10 && !crc_done);

endmodule

/* src/stream_reg.sv */
`timescale 1ns/1ps

module stream_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     aclk,
    input  logic     rst,

    input  payload_t s_payload,
    input  logic     s_valid,
    output logic     s_ready,

    output payload_t m_payload,
    output logic     m_valid,
    input  logic     m_ready
);

    payload_t skid_payload;
    logic     skid_valid;
    logic     out_free;
    logic     s_fire;

    assign out_free = !m_valid || m_ready;    // output slot is empty or drains this cycle
    assign s_fire   = s_valid && s_ready;

    // s_ready is a register of its own so upstream never sees m_ready combinationally
    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b0;
        end else if (out_free) begin
            m_valid    <= skid_valid || s_fire;
            skid_valid <= 1'b0;
            s_ready    <= 1'b1;
        end else if (s_fire) begin
            // output is stalled, park the beat that was already on its way in
            skid_valid <= 1'b1;
            s_ready    <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_free) begin
            m_payload <= skid_valid ? skid_payload : s_payload;
        end
        if (s_fire && !out_free) begin
            skid_payload <= s_payload;
        end
    end

    a_hold_stalled: assert property (@(posedge aclk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_payload));

    a_skid_no_overwrite: assert property (@(posedge aclk) disable iff (rst)
        s_fire && !out_free |-> !skid_valid);

endmodule

/* src/pixel_pkg.sv */
package pixel_pkg;

    localparam int byte_width   = 8;
    localparam int pixel_width  = 10;

    // five RAW10 bytes pack four pixels
    localparam int group_bytes  = 5;
    localparam int group_pixels = 4;

    // one beat of the incoming lane byte stream
    typedef struct packed {
        logic [byte_width-1:0] data;
    } byte_beat_t;

    // one beat of the outgoing pixel stream
    typedef struct packed {
        logic [pixel_width-1:0] pixel;
        logic                   frame_start;    // first pixel after a frame start packet
        logic                   line_end;       // last pixel of a long packet
    } pixel_beat_t;

endpackage

/* src/csi2_pkg.sv */
package csi2_pkg;

    // data type codes carried in bits 5..0 of the data identifier
    localparam logic [5:0] dt_frame_start = 6'h00;
    localparam logic [5:0] dt_frame_end   = 6'h01;
    localparam logic [5:0] dt_raw10       = 6'h2b;

    // codes up to this value are short packets, everything above is long
    localparam logic [5:0] dt_short_max   = 6'h0f;

    // data identifier, two word count bytes and the ECC byte
    localparam int header_bytes = 4;

    localparam int crc_bytes    = 2;    // checksum trailing every long packet

    // word count in bytes, sent LSB first
    localparam int wc_width     = 16;

endpackage
